//--- Makefile
# Verilator build and run of the UART testbench

TOP             ?= uart_tb
FILELIST        ?= uart_top.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert --timescale 1ns/100ps
BUILD_DIR       ?= obj_dir
PASS_TEXT       ?= Simulation finished: PASS

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- baud_gen.sv
`include "uart_defs.svh"

module baud_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`UART_DIV_WIDTH-1:0] divisor,   // period is divisor+1 clocks
  output logic                       tick_16x   // one-cycle 16x baud enable
);

  logic [`UART_DIV_WIDTH-1:0] count;      // down counter to next tick
  logic [`UART_DIV_WIDTH-1:0] divisor_q;  // divisor seen last cycle
  logic                       div_change; // new rate requested

  assign div_change = (divisor != divisor_q);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      count     <= '0;
      divisor_q <= '0;
      tick_16x  <= 1'b0;  // no tick right out of reset
    end
    else
    begin
      divisor_q <= divisor;
      if (div_change)
      begin
        count    <= divisor;  // restart the period at the new rate
        tick_16x <= 1'b0;
      end
      else if (count == '0)
      begin
        count    <= divisor;  // reload and fire
        tick_16x <= 1'b1;
      end
      else
      begin
        count    <= count - 1'b1;
        tick_16x <= 1'b0;
      end
    end
  end

  // back-to-back ticks only at the full clock rate
  tick_gap_a: assert property (@(posedge clk) disable iff (rst)
    tick_16x |=> (!tick_16x || $past(divisor) == '0));

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,  // clk period
  parameter int RESET_CYCLES = 2     // rising edges with rst held high
) (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // free running
  end

  initial
  begin
    rst = 1'b1;  // asserted from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// character format shared by transmitter and receiver
// 8N1 only, no parity and a single stop bit

// data bits per character, sent LSB first
`define UART_DATA_BITS 8

// baud ticks per bit time
// the receiver samples at tick 8 of 16, the transmitter holds each bit for 16
`define UART_OVERSAMPLE 16

// width of the run-time divisor input of the baud timer
// tick rate is clk / (divisor + 1)
`define UART_DIV_WIDTH 16

// a 9600 baud port on a 10 MHz clock needs a divisor of about 64
// a divisor of 0 gives one tick per clk cycle, handy in simulation

// the receiver needs at least 8 ticks of low line before it
// accepts a start bit, so noise shorter than half a bit is dropped

`endif

//--- uart_pkg.sv
`include "uart_defs.svh"

package uart_pkg;

  // transmitter status levels, both high when the port is idle
  typedef struct packed {
    logic tbre;  // holding buffer empty, a write is accepted
    logic tsre;  // shift register empty, no data bit left to send
  } uart_tx_status_t;

  // one received character plus its frame check
  // loaded once per frame at the stop-bit sample
  typedef struct packed {
    logic [`UART_DATA_BITS-1:0] data;       // assembled byte, first bit in lsb
    logic                       frame_err;  // stop bit sampled low
  } uart_rx_word_t;

  // the receive word is held until the next rx_valid pulse
  // a frame error does not suppress the data byte

endpackage

//--- uart_rx.sv
`include "uart_defs.svh"

module uart_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    tick_16x,  // 16x baud enable
  input  logic                    line,      // async serial input
  output logic                    rx_valid,  // one-cycle result strobe
  output uart_pkg::uart_rx_word_t rx_word    // byte and frame check
);
  import uart_pkg::*;

  localparam int OS_W  = $clog2(`UART_OVERSAMPLE);
  localparam int IDX_W = $clog2(`UART_DATA_BITS);

  localparam logic [OS_W-1:0] HALF_LAST = OS_W'(`UART_OVERSAMPLE / 2 - 1);
  localparam logic [OS_W-1:0] FULL_LAST = OS_W'(`UART_OVERSAMPLE - 1);

  typedef enum logic [1:0] {
    IDLE,   // wait for a low line
    START,  // confirm start bit at mid-bit
    DATA,   // sample data bits
    STOP    // sample stop bit
  } rx_state_t;

  rx_state_t                  state;
  logic                       line_meta;  // first synchronizer stage
  logic                       line_sync;  // line in the clk domain
  logic [OS_W-1:0]            tick_cnt;   // ticks since last sample point
  logic [IDX_W-1:0]           bit_idx;    // data bit being received
  logic [`UART_DATA_BITS-1:0] shreg;      // bytes assembled from the top
  uart_rx_word_t              word_d;     // result at the stop sample
  logic                       sample;     // mid-bit sample point

  assign sample = tick_16x & (tick_cnt == FULL_LAST);
  assign word_d = '{data: shreg, frame_err: ~line_sync};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      line_meta <= 1'b1;  // idle mark
      line_sync <= 1'b1;
    end
    else
    begin
      line_meta <= line;
      line_sync <= line_meta;
    end
  end

  // frame FSM, advances on ticks only
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;  // strobe by default
      if (tick_16x)
      begin
        case (state)
          IDLE:
          begin
            tick_cnt <= '0;
            if (!line_sync)
              state <= START;  // candidate start bit
          end
          START:
          begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == HALF_LAST)
            begin
              tick_cnt <= '0;  // mid start bit is now the phase reference
              bit_idx  <= '0;
              state    <= line_sync ? IDLE : DATA;  // high again means a glitch
            end
          end
          DATA:
          begin
            tick_cnt <= tick_cnt + 1'b1;  // wraps to 0 at each sample
            if (tick_cnt == FULL_LAST)
            begin
              bit_idx <= bit_idx + 1'b1;
              if (bit_idx == IDX_W'(`UART_DATA_BITS - 1))
                state <= STOP;
            end
          end
          STOP:
          begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == FULL_LAST)
            begin
              rx_valid <= 1'b1;  // result visible next cycle
              state    <= IDLE;
            end
          end
          default:
            state <= IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && state == DATA)
      shreg <= {line_sync, shreg[`UART_DATA_BITS-1:1]};  // lsb arrives first
    if (sample && state == STOP)
      rx_word <= word_d;  // held until the next frame
  end

  // a result never lasts more than one cycle
  valid_pulse_a: assert property (@(posedge clk) disable iff (rst)
    rx_valid |=> !rx_valid);

endmodule

//--- uart_tb.sv
`include "uart_defs.svh"

module uart_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import uart_pkg::*;

  localparam int NUM_FIXED = 8;  // hand-picked entries
  localparam int NUM_RAND  = 4;  // random loopback bytes appended
  localparam int NUM_TESTS = NUM_FIXED + NUM_RAND;
  localparam int OS        = `UART_OVERSAMPLE;
  localparam int FRAME_LEN = `UART_DATA_BITS + 2;

  typedef struct packed {
    logic [`UART_DATA_BITS-1:0] data;      // byte written or driven on sdi
    logic [`UART_DIV_WIDTH-1:0] div;       // baud divisor for the entry
    logic                       lb;        // loopback on
    logic                       b2b;       // second byte while the first shifts
    logic                       stop;      // stop bit level on sdi
    logic [`UART_DATA_BITS-1:0] exp_data;  // expected received byte
    logic                       exp_ferr;  // expected frame error
  } test_entry_t;

  logic                       clk;
  logic                       rst;
  logic [`UART_DIV_WIDTH-1:0] divisor;
  logic                       write;
  logic [`UART_DATA_BITS-1:0] din;
  logic                       sdo;
  uart_tx_status_t            tx_status;
  logic                       sdi;
  logic                       loopback;
  logic                       rx_valid;
  uart_rx_word_t              rx_word;

  test_entry_t   tbl [NUM_TESTS];
  uart_rx_word_t rx_q [$];    // received words in arrival order
  logic          tsre_q [$];  // tsre level seen with each rx_valid
  int            errors;
  int            failed_tests;
  int            seed;
  bit            table_ready;
  longint        wd_ns;

  tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

  uart_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .divisor   (divisor),
    .write     (write),
    .din       (din),
    .sdo       (sdo),
    .tx_status (tx_status),
    .sdi       (sdi),
    .loopback  (loopback),
    .rx_valid  (rx_valid),
    .rx_word   (rx_word)
  );

  always @(negedge clk)
  begin
    if (!rst && rx_valid)
    begin
      rx_q.push_back(rx_word);  // sampled mid-cycle where outputs are settled
      tsre_q.push_back(tx_status.tsre);
    end
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("mismatch at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0d ns: %s", $time, what);
    errors++;
  endtask

  task automatic build_table();
    logic [31:0] r;
    tbl[0] = '{8'ha5, 16'd0, 1'b1, 1'b0, 1'b1, 8'ha5, 1'b0};
    tbl[1] = '{8'h3c, 16'd3, 1'b1, 1'b0, 1'b1, 8'h3c, 1'b0};
    tbl[2] = '{8'h01, 16'd1, 1'b1, 1'b0, 1'b1, 8'h01, 1'b0};
    tbl[3] = '{8'h80, 16'd7, 1'b1, 1'b1, 1'b1, 8'h80, 1'b0};
    tbl[4] = '{8'hc3, 16'd2, 1'b0, 1'b0, 1'b0, 8'hc3, 1'b1};  // stop bit low
    tbl[5] = '{8'h5e, 16'd2, 1'b0, 1'b0, 1'b1, 8'h5e, 1'b0};  // clean after the bad one
    tbl[6] = '{8'hff, 16'd0, 1'b1, 1'b1, 1'b1, 8'hff, 1'b0};
    tbl[7] = '{8'h00, 16'd5, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0};
    for (int i = NUM_FIXED; i < NUM_TESTS; i++)
    begin
      r = $random(seed);
      tbl[i] = '{r[7:0], 16'(r[9:8]), 1'b1, 1'b0, 1'b1, r[7:0], 1'b0};  // loopback echoes
    end
  endtask

  task automatic wait_tbre_high(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!tx_status.tbre && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!tx_status.tbre)
      report_failure("holding buffer never became empty");
  endtask

  task automatic write_byte(input logic [7:0] b, input bit with_drop, input logic [7:0] drop);
    @(posedge clk);
    write <= 1'b1;
    din   <= b;
    @(posedge clk);  // byte taken on this edge
    if (with_drop)
      din <= drop;  // next strobe meets a full buffer
    else
      write <= 1'b0;
    @(negedge clk);
    if (tx_status.tbre !== 1'b0)
      report_mismatch("tx_status.tbre", 0, int'(tx_status.tbre));
    if (with_drop)
    begin
      @(posedge clk);
      write <= 1'b0;
    end
  endtask

  task automatic wait_start_bit(input int tick_cyc);
    int n;
    n = 0;
    @(negedge clk);
    while (sdo && n < (OS + 1) * tick_cyc + 4)  // at most one bit of alignment
    begin
      @(negedge clk);
      n++;
    end
    if (sdo)
      report_failure("no start bit on sdo after the write");
    else
    begin
      if (tx_status.tbre !== 1'b1)
        report_mismatch("tx_status.tbre", 1, int'(tx_status.tbre));
      if (tx_status.tsre !== 1'b0)
        report_mismatch("tx_status.tsre", 0, int'(tx_status.tsre));
    end
  endtask

  task automatic drive_frame(input logic [7:0] b, input logic stop_bit, input int bit_cyc);
    logic [FRAME_LEN-1:0] frame;
    frame = {stop_bit, b, 1'b0};  // start bit goes first
    for (int i = 0; i < FRAME_LEN; i++)
    begin
      @(posedge clk);
      sdi <= frame[i];
      repeat (bit_cyc - 1) @(posedge clk);
    end
    @(posedge clk);
    sdi <= 1'b1;  // back to mark
  endtask

  task automatic wait_results(input int count, input int limit);
    int n;
    n = 0;
    while (rx_q.size() < count && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (rx_q.size() < count)
      report_failure($sformatf("only %0d of %0d bytes received", rx_q.size(), count));
  endtask

  task automatic check_result(input logic [7:0] exp_data, input logic exp_ferr);
    uart_rx_word_t got;
    logic          tsre_seen;
    if (rx_q.size() != 0)
    begin
      got       = rx_q.pop_front();
      tsre_seen = tsre_q.pop_front();
      if (got.data !== exp_data)
        report_mismatch("rx_word.data", int'(exp_data), int'(got.data));
      if (got.frame_err !== exp_ferr)
        report_mismatch("rx_word.frame_err", int'(exp_ferr), int'(got.frame_err));
      if (tsre_seen !== 1'b1)
        report_mismatch("tx_status.tsre", 1, int'(tsre_seen));
    end
  endtask

  task automatic run_entry(input test_entry_t e);
    int tick_cyc;
    int bit_cyc;
    int frames;
    tick_cyc = int'(e.div) + 1;
    bit_cyc  = OS * tick_cyc;
    frames   = e.b2b ? 2 : 1;
    @(posedge clk);
    divisor  <= e.div;
    loopback <= e.lb;
    repeat (2 * tick_cyc + 4) @(posedge clk);  // timer restarts on the new divisor
    if (e.lb)
    begin
      wait_tbre_high(12 * bit_cyc);
      write_byte(e.data, e.b2b, e.data ^ 8'h3c);
      wait_start_bit(tick_cyc);
      if (e.b2b)
      begin
        wait_tbre_high(12 * bit_cyc);
        write_byte(~e.data, 1'b0, 8'h00);  // queued behind the first frame
      end
    end
    else
      drive_frame(e.data, e.stop, bit_cyc);
    wait_results(frames, 12 * frames * bit_cyc);
    check_result(e.exp_data, e.exp_ferr);
    if (e.b2b)
      check_result(~e.exp_data, 1'b0);
    repeat (2 * bit_cyc) @(posedge clk);  // idle line between entries
    if (rx_q.size() != 0)
      report_failure("receiver produced an unexpected byte");
    rx_q.delete();
    tsre_q.delete();
  endtask

  task automatic finish_test(input int num, input string name, input int errs_before);
    if (errors == errs_before)
      $display("test %0d %s: ok", num, name);
    else
    begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
      failed_tests++;
    end
  endtask

  initial
  begin
    int    errs;
    int    max_div;
    string name;
    errors       = 0;
    failed_tests = 0;
    seed         = 32'h5134_b349;
    divisor      = '0;
    write        = 1'b0;
    din          = '0;
    sdi          = 1'b1;  // mark
    loopback     = 1'b0;
    build_table();
    max_div = 0;
    for (int i = 0; i < NUM_TESTS; i++)
      if (int'(tbl[i].div) > max_div)
        max_div = int'(tbl[i].div);
    wd_ns       = longint'(NUM_TESTS) * 12 * OS * (max_div + 1) * 100 * 2;
    table_ready = 1'b1;

    wait (rst === 1'b0);
    errs = errors;
    @(negedge clk);
    if (sdo !== 1'b1)
      report_mismatch("sdo", 1, int'(sdo));
    if (tx_status.tbre !== 1'b1)
      report_mismatch("tx_status.tbre", 1, int'(tx_status.tbre));
    if (tx_status.tsre !== 1'b1)
      report_mismatch("tx_status.tsre", 1, int'(tx_status.tsre));
    repeat (64) @(posedge clk);  // line idles high
    if (rx_q.size() != 0)
      report_failure("rx_valid pulsed on an idle line");
    finish_test(0, "reset state", errs);

    for (int i = 0; i < NUM_TESTS; i++)
    begin
      errs = errors;
      name = tbl[i].lb ? (tbl[i].b2b ? "loopback back-to-back" : "loopback") : "sdi frame";
      run_entry(tbl[i]);
      finish_test(i + 1, $sformatf("%s byte %02h div %0d", name, tbl[i].data, tbl[i].div),
                  errs);
    end

    errs = errors;
    @(posedge clk);
    loopback <= 1'b0;
    divisor  <= 16'd3;
    repeat (16) @(posedge clk);
    sdi <= 1'b0;
    repeat (4 * 4) @(posedge clk);  // 4 ticks low is half of the 8 needed
    sdi <= 1'b1;
    repeat (12 * OS * 4) @(posedge clk);  // longer than a whole frame
    if (rx_q.size() != 0)
      report_failure("short glitch on sdi was taken as a start bit");
    finish_test(NUM_TESTS + 1, "false start", errs);

    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS + 2, failed_tests, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    wait (table_ready);
    #(wd_ns);
    $display("error: watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- uart_top.f
+incdir+.
uart_pkg.sv
baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_clock_gen.sv
uart_tb.sv

//--- uart_top.sv
`include "uart_defs.svh"

module uart_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`UART_DIV_WIDTH-1:0] divisor,    // baud rate select
  input  logic                       write,      // send strobe
  input  logic [`UART_DATA_BITS-1:0] din,        // byte to send
  output logic                       sdo,        // serial out
  output uart_pkg::uart_tx_status_t  tx_status,  // transmitter levels
  input  logic                       sdi,        // serial in
  input  logic                       loopback,   // route sdo back to receiver
  output logic                       rx_valid,   // received byte strobe
  output uart_pkg::uart_rx_word_t    rx_word     // received byte and frame check
);
  import uart_pkg::*;

  logic tick_16x;  // shared 16x baud enable
  logic rx_line;   // receiver input after loopback select

  assign rx_line = loopback ? sdo : sdi;  // no register, purely a mux

  baud_gen baud_gen_i (
    .clk      (clk),
    .rst      (rst),
    .divisor  (divisor),
    .tick_16x (tick_16x)
  );

  uart_tx uart_tx_i (
    .clk       (clk),
    .rst       (rst),
    .tick_16x  (tick_16x),
    .write     (write),
    .din       (din),
    .sdo       (sdo),
    .tx_status (tx_status)
  );

  uart_rx uart_rx_i (
    .clk      (clk),
    .rst      (rst),
    .tick_16x (tick_16x),
    .line     (rx_line),
    .rx_valid (rx_valid),
    .rx_word  (rx_word)
  );

endmodule

//--- uart_tx.sv
`include "uart_defs.svh"

module uart_tx (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       tick_16x,  // 16x baud enable
  input  logic                       write,     // load strobe, one cycle
  input  logic [`UART_DATA_BITS-1:0] din,       // byte to send
  output logic                       sdo,       // serial out, idles high
  output uart_pkg::uart_tx_status_t  tx_status  // tbre / tsre levels
);
  import uart_pkg::*;

  localparam int DIV_W    = $clog2(`UART_OVERSAMPLE);
  localparam int CNT_W    = $clog2(`UART_DATA_BITS + 3);
  localparam int LAST_BIT = `UART_DATA_BITS + 1;  // step that puts the stop bit out
  localparam int STOP_END = `UART_DATA_BITS + 2;  // stop bit has run its full time

  logic [`UART_DATA_BITS-1:0] tbr;        // holding buffer
  logic [`UART_DATA_BITS-1:0] tsr;        // shift register, fills with ones
  uart_tx_status_t            status;     // registered status levels
  logic [DIV_W-1:0]           clkdiv;     // 16x to 1x divider
  logic [CNT_W-1:0]           bit_cnt;    // 0 idle, 1 start, 2..9 data, 10 stop
  logic                       char_busy;  // character waiting or on the line
  logic                       clk1xe;     // 1x bit boundary enable
  logic                       accept;     // write taken into the buffer
  logic                       load;       // buffer moves into shift register

  assign accept    = write & status.tbre;  // writes while full are dropped
  assign char_busy = (bit_cnt != '0) | ~status.tbre;
  assign clk1xe    = tick_16x & (clkdiv == DIV_W'(`UART_OVERSAMPLE - 1)) & char_busy;
  assign tx_status = status;

  // a new frame starts on a bit boundary, from idle or right after a stop bit
  assign load = clk1xe & ~status.tbre &
                ((bit_cnt == '0) | (bit_cnt == CNT_W'(STOP_END)));

  // tick divider free runs so bit boundaries keep a fixed phase;
  // only the enable it produces is gated by char_busy
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      clkdiv <= '0;
    else if (tick_16x)
      clkdiv <= clkdiv + 1'b1;  // wraps every bit time
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      tbr <= din;  // hold until the next bit boundary
  end

  always_ff @(posedge clk)
  begin
    if (load)
      tsr <= tbr;
    else if (clk1xe && bit_cnt != '0 && bit_cnt != CNT_W'(STOP_END))
      tsr <= {1'b1, tsr[`UART_DATA_BITS-1:1]};  // lsb first, ones fill the top
  end

  // bit sequencer and status levels
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      status  <= '{tbre: 1'b1, tsre: 1'b1};
      sdo     <= 1'b1;  // line idles at mark
      bit_cnt <= '0;
    end
    else
    begin
      if (accept)
        status.tbre <= 1'b0;  // buffer now full
      if (load)
      begin
        status.tbre <= 1'b1;  // byte moved on, room for the next one
        status.tsre <= 1'b0;
        sdo         <= 1'b0;  // start bit
        bit_cnt     <= CNT_W'(1);
      end
      else if (clk1xe)
      begin
        if (bit_cnt == CNT_W'(STOP_END))
          bit_cnt <= '0;  // frame done and nothing buffered
        else if (bit_cnt != '0)
        begin
          sdo     <= tsr[0];  // data bits, then a fill one as stop bit
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(LAST_BIT))
            status.tsre <= 1'b1;  // last data bit has gone out
        end
      end
    end
  end

  // tbre only drops because a write was taken
  tbre_fall_a: assert property (@(posedge clk) disable iff (rst)
    $fell(status.tbre) |-> $past(write));

  // nothing buffered and nothing shifting means the line sits at mark
  idle_line_a: assert property (@(posedge clk) disable iff (rst)
    (status.tbre && status.tsre) |-> sdo);

endmodule
